// ==== verilog.f ====
src/mips_pkg.sv
src/reg_file.sv
src/instr_decode.sv
src/alu_execute.sv
src/data_memory.sv
src/mem_stage.sv
src/write_back.sv
src/mips_core_top.sv
sim/tb_mips_core.sv

// ==== Bender.yml ====
package:
  name: mips_core

sources:
  - src/mips_pkg.sv
  - src/reg_file.sv
  - src/instr_decode.sv
  - src/alu_execute.sv
  - src/data_memory.sv
  - src/mem_stage.sv
  - src/write_back.sv
  - src/mips_core_top.sv
  - target: simulation
    files:
      - sim/tb_mips_core.sv

// ==== sim/tb_mips_core.sv ====
`timescale 1ns/100ps

module tb_mips_core import mips_pkg::*; ();

   localparam int CLK_PERIOD = 4;
   localparam int LATENCY    = 3;   // ack cycle to result cycle
   localparam int BASE_REG   = 30;  // points at the middle of the load/store window

   logic               i_clk;
   logic               i_rst;
   logic               i_wb_cyc;
   logic               i_wb_stb;
   logic               i_wb_we;
   logic [NB_DATA-1:0] i_wb_dat;
   logic [NB_DATA-1:0] o_wb_dat;
   logic               o_wb_ack;
   logic               o_res_valid;
   wb_result_t         o_res;

   // reference state
   logic [31:0] ref_regs [32];
   logic [7:0]  ref_mem [1024];

   wb_result_t exp_q [$];
   int         ack_q [$];   // ack cycle of each entry in exp_q

   int cycle_cnt  = 0;
   int n_issued   = 0;
   int n_expected = 0;
   int n_results  = 0;
   int ack_seen   = 0;
   int n_checks   = 0;
   int errors     = 0;

   mips_core_top dut (
      .i_clk       (i_clk),
      .i_rst       (i_rst),
      .i_wb_cyc    (i_wb_cyc),
      .i_wb_stb    (i_wb_stb),
      .i_wb_we     (i_wb_we),
      .i_wb_dat    (i_wb_dat),
      .o_wb_dat    (o_wb_dat),
      .o_wb_ack    (o_wb_ack),
      .o_res_valid (o_res_valid),
      .o_res       (o_res)
   );

   initial begin
      i_clk = 1'b0;
      forever #(CLK_PERIOD/2) i_clk = ~i_clk;
   end

   function automatic logic [31:0] r_format(input logic [5:0] fn, input logic [4:0] rs,
                                            input logic [4:0] rt, input logic [4:0] rd);
      return {6'h00, rs, rt, rd, 5'h00, fn};
   endfunction

   function automatic logic [31:0] i_format(input logic [5:0] op, input logic [4:0] rs,
                                            input logic [4:0] rt, input logic [15:0] imm);
      return {op, rs, rt, imm};
   endfunction

   function automatic logic [31:0] fill_word(input logic [31:0] addr);
      return (addr + 32'd1) * 32'h9e3779b9;
   endfunction

   // runs one instruction on the reference machine and returns 1 when a result is due
   function automatic bit ref_exec(input logic [31:0] instr, output wb_result_t res);
      logic [5:0]  op;
      logic [4:0]  rs;
      logic [4:0]  rt;
      logic [4:0]  dst;
      logic [31:0] a;
      logic [31:0] b;
      logic [31:0] simm;
      logic [31:0] val;
      logic [9:0]  ba;
      logic [15:0] half;
      logic [7:0]  byte_v;
      bit          wr;
      op     = instr[31:26];
      rs     = instr[25:21];
      rt     = instr[20:16];
      a      = ref_regs[rs];
      b      = ref_regs[rt];
      simm   = {{16{instr[15]}}, instr[15:0]};
      ba     = 10'(a + simm);                  // byte address with low bits ignored per size
      half   = {ref_mem[{ba[9:1], 1'b1}], ref_mem[{ba[9:1], 1'b0}]};
      byte_v = ref_mem[ba];
      dst    = rt;
      val    = '0;
      wr     = 1'b1;
      case (op)
         OP_RTYPE: begin
            dst = instr[15:11];
            case (instr[5:0])
               F_ADDU:  val = a + b;
               F_SUBU:  val = a - b;
               F_AND:   val = a & b;
               F_OR:    val = a | b;
               F_XOR:   val = a ^ b;
               F_SLT:   val = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
               default: wr = 1'b0;
            endcase
         end
         OP_ADDIU: val = a + simm;
         OP_ANDI:  val = a & {16'h0000, instr[15:0]};
         OP_ORI:   val = a | {16'h0000, instr[15:0]};
         OP_LUI:   val = {instr[15:0], 16'h0000};
         OP_LW: begin
            val = {ref_mem[{ba[9:2], 2'd3}], ref_mem[{ba[9:2], 2'd2}],
                   ref_mem[{ba[9:2], 2'd1}], ref_mem[{ba[9:2], 2'd0}]};
         end
         OP_LH:    val = {{16{half[15]}}, half};
         OP_LHU:   val = {16'h0000, half};
         OP_LB:    val = {{24{byte_v[7]}}, byte_v};
         OP_LBU:   val = {24'h000000, byte_v};
         OP_SW: begin
            wr = 1'b0;
            for (int i = 0; i < 4; i++) begin
               ref_mem[{ba[9:2], 2'(i)}] = b[8*i +: 8];
            end
         end
         OP_SH: begin
            wr = 1'b0;
            ref_mem[{ba[9:1], 1'b0}] = b[7:0];
            ref_mem[{ba[9:1], 1'b1}] = b[15:8];
         end
         OP_SB: begin
            wr          = 1'b0;
            ref_mem[ba] = b[7:0];
         end
         default: wr = 1'b0;
      endcase
      if (dst == 5'd0) wr = 1'b0;   // r0 stays zero and is not reported
      if (wr) ref_regs[dst] = val;
      res = '{idx: dst, data: val};
      return wr;
   endfunction

   // sources and destinations in r0..r15 with memory through the base register
   function automatic logic [31:0] rand_instr(input bit alu_only);
      logic [4:0]  rs;
      logic [4:0]  rt;
      logic [4:0]  rd;
      logic [15:0] imm;
      logic [15:0] ofs;
      logic [5:0]  fn;
      logic [5:0]  op;
      int          kind;
      rs   = 5'($urandom_range(0, 15));
      rt   = 5'($urandom_range(0, 15));
      rd   = 5'($urandom_range(0, 15));
      imm  = 16'($urandom);
      ofs  = 16'($urandom_range(0, 63)) - 16'd32;
      kind = alu_only ? $urandom_range(0, 9) : $urandom_range(0, 17);
      if (kind < 6) begin
         case (kind)
            0:       fn = F_ADDU;
            1:       fn = F_SUBU;
            2:       fn = F_AND;
            3:       fn = F_OR;
            4:       fn = F_XOR;
            default: fn = F_SLT;
         endcase
         return r_format(fn, rs, rt, rd);
      end
      case (kind)
         6:       op = OP_ADDIU;
         7:       op = OP_ANDI;
         8:       op = OP_ORI;
         9:       op = OP_LUI;
         10:      op = OP_LB;
         11:      op = OP_LBU;
         12:      op = OP_LH;
         13:      op = OP_LHU;
         14:      op = OP_LW;
         15:      op = OP_SB;
         16:      op = OP_SH;
         default: op = OP_SW;
      endcase
      if (kind >= 10) return i_format(op, 5'(BASE_REG), rt, ofs);
      if (kind == 9) rs = 5'd0;
      return i_format(op, rs, rt, imm);
   endfunction

   task automatic check_result(input wb_result_t got, input wb_result_t expd);
      n_checks++;
      if (got !== expd) begin
         errors++;
         $display("error at %0t ns: write r%0d = %h, expected r%0d = %h",
                  $time, got.idx, got.data, expd.idx, expd.data);
      end
   endtask

   task automatic check_count(input string what, input int got, input int expd);
      n_checks++;
      if (got != expd) begin
         errors++;
         $display("error at %0t ns: %s count %0d, expected %0d", $time, what, got, expd);
      end
   endtask

   task automatic compare_rdata(input logic [NB_DATA-1:0] got,
                                input logic [NB_DATA-1:0] expd);
      n_checks++;
      if (got !== expd) begin
         errors++;
         $display("error at %0t ns: wishbone read data %h, expected %h", $time, got, expd);
      end
   endtask

   task automatic match_latency(input int got);
      n_checks++;
      if (got != LATENCY) begin
         errors++;
         $display("error at %0t ns: result %0d cycles after ack, expected %0d",
                  $time, got, LATENCY);
      end
   endtask

   task automatic print_counts();
      $display("checks %0d, errors %0d, acks %0d of %0d issued, results %0d of %0d",
               n_checks, errors, ack_seen, n_issued, n_results, n_expected);
   endtask

   // one wishbone write cycle held until the ack
   task automatic issue_instr(input logic [31:0] instr, input int gap);
      wb_result_t expd;
      @(negedge i_clk);
      i_wb_cyc = 1'b1;
      i_wb_stb = 1'b1;
      i_wb_we  = 1'b1;
      i_wb_dat = instr;
      n_issued++;
      #1;
      while (!o_wb_ack) begin   // scoreboard stall
         @(negedge i_clk);
         #1;
      end
      if (ref_exec(instr, expd)) begin
         exp_q.push_back(expd);
         ack_q.push_back(cycle_cnt);
         n_expected++;
      end
      @(negedge i_clk);
      i_wb_cyc = 1'b0;
      i_wb_stb = 1'b0;
      i_wb_we  = 1'b0;
      repeat (gap - 1) @(negedge i_clk);
   endtask

   // wishbone read with an instruction on the data lines that must not execute
   task automatic wb_read(input logic [31:0] instr);
      @(negedge i_clk);
      i_wb_cyc = 1'b1;
      i_wb_stb = 1'b1;
      i_wb_we  = 1'b0;
      i_wb_dat = instr;
      n_issued++;
      #1;
      while (!o_wb_ack) begin
         @(negedge i_clk);
         #1;
      end
      compare_rdata(o_wb_dat, '0);
      @(negedge i_clk);
      i_wb_cyc = 1'b0;
      i_wb_stb = 1'b0;
   endtask

   task automatic set_reg(input logic [4:0] idx, input logic [31:0] val);
      issue_instr(i_format(OP_LUI, 5'd0, idx, val[31:16]), 1);
      issue_instr(i_format(OP_ORI, idx, idx, val[15:0]), 1);
   endtask

   always @(posedge i_clk) begin
      if (!i_rst && o_wb_ack) ack_seen++;
   end

   // result monitor comparing in issue order
   initial begin : monitor
      wb_result_t expd;
      int         ack_cyc;
      forever begin
         @(negedge i_clk);
         if (!i_rst && o_res_valid) begin
            n_results++;
            if (exp_q.size() == 0) begin
               errors++;
               $display("unexpected register write to r%0d at %0t ns with no result pending",
                        o_res.idx, $time);
            end else begin
               expd    = exp_q.pop_front();
               ack_cyc = ack_q.pop_front();
               check_result(o_res, expd);
               match_latency(cycle_cnt - ack_cyc);
            end
         end
      end
   end

   initial begin : watchdog
      while (cycle_cnt <= 40 * n_issued + 100) begin
         @(posedge i_clk);
         cycle_cnt++;
      end
      $display("hang: run stopped after %0d cycles, %0d instructions issued, %0d acked",
               cycle_cnt, n_issued, ack_seen);
      print_counts();
      $display("RESULT: FAIL");
      $finish;
   end

   initial begin : stimulus
      logic [5:0]  st_op;
      logic [31:0] pat;
      void'($urandom(32'hf9a2));
      i_rst    = 1'b1;
      i_wb_cyc = 1'b0;
      i_wb_stb = 1'b0;
      i_wb_we  = 1'b0;
      i_wb_dat = '0;
      for (int i = 0; i < 32; i++) ref_regs[i] = '0;
      for (int i = 0; i < 1024; i++) ref_mem[i] = '0;
      repeat (2) @(posedge i_clk);
      @(negedge i_clk);
      i_rst = 1'b0;

      // base register and a 16 word window filled from its address
      issue_instr(i_format(OP_ADDIU, 5'd0, 5'(BASE_REG), 16'd32), 1);
      for (int a = 0; a < 64; a += 4) begin
         set_reg(5'd1, fill_word(a));
         issue_instr(i_format(OP_SW, 5'(BASE_REG), 5'd1, 16'(a - 32)), 1);
      end

      // alu and immediate ops with r0 as a destination too
      for (int r = 1; r < 16; r++) set_reg(5'(r), $urandom);
      issue_instr(r_format(F_ADDU, 5'd1, 5'd2, 5'd0), 1);
      issue_instr(i_format(OP_ORI, 5'd3, 5'd0, 16'hffff), 1);
      repeat (40) issue_instr(rand_instr(1'b1), $urandom_range(1, 2));

      // reads and unsupported encodings leave the registers alone
      issue_instr(i_format(OP_ADDIU, 5'd2, 5'd1, 16'h0100), 1);
      wb_read(r_format(F_ADDU, 5'd1, 5'd2, 5'd13));   // r1 still in flight
      wb_read(i_format(OP_ADDIU, 5'd0, 5'd14, 16'h1234));
      issue_instr(r_format(6'h00, 5'd1, 5'd2, 5'd13), 1);   // unsupported funct
      issue_instr(i_format(6'h02, 5'd1, 5'd14, 16'h0010), 1);   // unsupported opcode

      // every store size at every lane read back as a word
      for (int sz = 0; sz < 3; sz++) begin
         st_op = (sz == 0) ? OP_SB : (sz == 1) ? OP_SH : OP_SW;
         for (int lane = 0; lane < 4; lane++) begin
            set_reg(5'd2, $urandom);
            issue_instr(i_format(st_op, 5'(BASE_REG), 5'd2, 16'(lane - 24)), 1);
            issue_instr(i_format(OP_LW, 5'(BASE_REG), 5'd3, 16'(lane - 24)), 1);
         end
      end

      // signed and unsigned narrow loads from every lane
      for (int k = 0; k < 2; k++) begin
         pat = (k == 0) ? 32'h80ff7f01 : $urandom;
         set_reg(5'd2, pat);
         issue_instr(i_format(OP_SW, 5'(BASE_REG), 5'd2, 16'hffec), 1);
         for (int lane = 0; lane < 4; lane++) begin
            issue_instr(i_format(OP_LB, 5'(BASE_REG), 5'd4, 16'(lane - 20)), 1);
            issue_instr(i_format(OP_LBU, 5'(BASE_REG), 5'd5, 16'(lane - 20)), 1);
            issue_instr(i_format(OP_LH, 5'(BASE_REG), 5'd6, 16'(lane - 20)), 1);
            issue_instr(i_format(OP_LHU, 5'(BASE_REG), 5'd7, 16'(lane - 20)), 1);
         end
      end

      // dependent chains that need the stall
      issue_instr(r_format(F_ADDU, 5'd2, 5'd3, 5'd1), 1);
      issue_instr(r_format(F_ADDU, 5'd1, 5'd1, 5'd4), 1);
      issue_instr(r_format(F_SUBU, 5'd4, 5'd1, 5'd6), 1);
      issue_instr(i_format(OP_LW, 5'(BASE_REG), 5'd7, 16'hfff0), 1);
      issue_instr(r_format(F_ADDU, 5'd7, 5'd7, 5'd8), 1);           // load then use
      issue_instr(i_format(OP_SW, 5'(BASE_REG), 5'd8, 16'hfff4), 1);
      issue_instr(i_format(OP_LW, 5'(BASE_REG), 5'd9, 16'hfff4), 1);
      issue_instr(r_format(F_XOR, 5'd9, 5'd8, 5'd10), 1);
      issue_instr(i_format(OP_LUI, 5'd0, 5'd11, 16'h8234), 1);
      issue_instr(i_format(OP_ORI, 5'd11, 5'd11, 16'h5678), 1);
      issue_instr(r_format(F_SLT, 5'd11, 5'd10, 5'd12), 1);

      // random mix with random strobe gaps
      repeat (300) issue_instr(rand_instr(1'b0), $urandom_range(1, 3));

      while (exp_q.size() != 0) @(negedge i_clk);
      repeat (LATENCY + 1) @(negedge i_clk);   // room for a stray write
      check_count("acknowledged cycles", ack_seen, n_issued);
      check_count("results", n_results, n_expected);
      print_counts();
      if (errors == 0) begin
         $display("RESULT: PASS");
      end else begin
         $display("RESULT: FAIL");
      end
      $finish;
   end

endmodule

// ==== src/mips_core_top.sv ====
`timescale 1ns/100ps

module mips_core_top import mips_pkg::*; (
   input  logic               i_clk,
   input  logic               i_rst,
   input  logic               i_wb_cyc,
   input  logic               i_wb_stb,
   input  logic               i_wb_we,
   input  logic [NB_DATA-1:0] i_wb_dat,
   output logic [NB_DATA-1:0] o_wb_dat,
   output logic               o_wb_ack,
   output logic               o_res_valid,
   output wb_result_t         o_res
);

   logic [NB_REG-1:0]  rs_idx;
   logic [NB_REG-1:0]  rt_idx;
   logic [NB_DATA-1:0] rs_data;
   logic [NB_DATA-1:0] rt_data;
   id_ex_t             id_ex;
   logic               id_valid;
   ex_mem_t            ex_mem;
   logic               ex_valid;
   logic [NB_DATA-1:0] mem_data;
   logic [NB_DATA-1:0] alu_data;
   ctrl_wb_t           wb_ctl;
   logic               mem_valid;
   logic               rf_we;
   logic [NB_REG-1:0]  rf_idx;
   logic [NB_DATA-1:0] rf_data;

   instr_decode u_decode (
      .i_clk      (i_clk),
      .i_rst      (i_rst),
      .i_wb_cyc   (i_wb_cyc),
      .i_wb_stb   (i_wb_stb),
      .i_wb_we    (i_wb_we),
      .i_wb_dat   (i_wb_dat),
      .o_wb_dat   (o_wb_dat),
      .o_wb_ack   (o_wb_ack),
      .o_rs_idx   (rs_idx),
      .o_rt_idx   (rt_idx),
      .i_rs_data  (rs_data),
      .i_rt_data  (rt_data),
      .i_ex_wb    (id_ex.wb),    // now in execute
      .i_mem_wb   (ex_mem.wb),   // now in memory
      .o_id_ex    (id_ex),
      .o_id_valid (id_valid)
   );

   reg_file u_rf (
      .i_clk     (i_clk),
      .i_rst     (i_rst),
      .i_rs_idx  (rs_idx),
      .i_rt_idx  (rt_idx),
      .o_rs_data (rs_data),
      .o_rt_data (rt_data),
      .i_we      (rf_we),
      .i_wr_idx  (rf_idx),
      .i_wr_data (rf_data)
   );

   alu_execute u_exec (
      .i_clk      (i_clk),
      .i_rst      (i_rst),
      .i_id_ex    (id_ex),
      .i_id_valid (id_valid),
      .o_ex_mem   (ex_mem),
      .o_ex_valid (ex_valid)
   );

   mem_stage u_mem (
      .i_clk       (i_clk),
      .i_rst       (i_rst),
      .i_ex_mem    (ex_mem),
      .i_ex_valid  (ex_valid),
      .o_mem_data  (mem_data),
      .o_alu_data  (alu_data),
      .o_wb_ctl    (wb_ctl),
      .o_mem_valid (mem_valid)
   );

   write_back u_wb (
      .i_mem_data  (mem_data),
      .i_alu_data  (alu_data),
      .i_wb_ctl    (wb_ctl),
      .i_addr_lo   (alu_data[1:0]),
      .i_mem_valid (mem_valid),
      .o_rf_we     (rf_we),
      .o_rf_idx    (rf_idx),
      .o_rf_data   (rf_data),
      .o_res_valid (o_res_valid),
      .o_res       (o_res)
   );

endmodule

// ==== src/write_back.sv ====
`timescale 1ns/100ps

module write_back import mips_pkg::*; (
   input  logic [NB_DATA-1:0] i_mem_data,
   input  logic [NB_DATA-1:0] i_alu_data,
   input  ctrl_wb_t           i_wb_ctl,
   input  logic [1:0]         i_addr_lo,
   input  logic               i_mem_valid,
   output logic               o_rf_we,
   output logic [NB_REG-1:0]  o_rf_idx,
   output logic [NB_DATA-1:0] o_rf_data,
   output logic               o_res_valid,
   output wb_result_t         o_res
);

   logic [NB_BYTE-1:0] ld_byte;
   logic [15:0]        ld_half;
   logic [NB_DATA-1:0] ld_val;

   assign ld_byte = i_mem_data[i_addr_lo*NB_BYTE +: NB_BYTE];
   assign ld_half = i_addr_lo[1] ? i_mem_data[31:16] : i_mem_data[15:0];

   always_comb begin
      case (i_wb_ctl.mem_size)
         MEM_BYTE: ld_val = ext_byte(ld_byte, i_wb_ctl.load_unsigned);
         MEM_HALF: ld_val = ext_half(ld_half, i_wb_ctl.load_unsigned);
         default:  ld_val = i_mem_data;
      endcase
   end

   assign o_rf_data = i_wb_ctl.mem_to_reg ? ld_val : i_alu_data;
   assign o_rf_idx  = i_wb_ctl.dst;
   assign o_rf_we   = i_mem_valid && i_wb_ctl.reg_write && (i_wb_ctl.dst != '0);  // r0 dropped

   assign o_res_valid = o_rf_we;
   assign o_res       = '{idx: o_rf_idx, data: o_rf_data};

endmodule

// ==== src/mem_stage.sv ====
`timescale 1ns/100ps

module mem_stage import mips_pkg::*; (
   input  logic               i_clk,
   input  logic               i_rst,
   input  ex_mem_t            i_ex_mem,
   input  logic               i_ex_valid,
   output logic [NB_DATA-1:0] o_mem_data,
   output logic [NB_DATA-1:0] o_alu_data,
   output ctrl_wb_t           o_wb_ctl,
   output logic               o_mem_valid
);

   logic [NB_MEM_ADDR-1:0] word_addr;
   logic [1:0]             addr_lo;
   logic [NB_DATA-1:0]     st_lanes;
   logic [NB_COL-1:0]      col_sel;
   logic [NB_COL-1:0]      col_we;

   assign word_addr = i_ex_mem.alu_res[NB_MEM_ADDR+1:2];
   assign addr_lo   = i_ex_mem.alu_res[1:0];   // ignored for word access

   // little endian lanes, byte n of the word sits in column n
   always_comb begin
      case (i_ex_mem.mem.mem_size)
         MEM_BYTE: begin
            st_lanes = {NB_COL{i_ex_mem.st_data[NB_BYTE-1:0]}};
            col_sel  = {{(NB_COL-1){1'b0}}, 1'b1} << addr_lo;
         end
         MEM_HALF: begin
            st_lanes = {2{i_ex_mem.st_data[15:0]}};
            col_sel  = {{2{addr_lo[1]}}, {2{~addr_lo[1]}}};
         end
         default: begin
            st_lanes = i_ex_mem.st_data;
            col_sel  = '1;
         end
      endcase
   end

   assign col_we = col_sel & {NB_COL{i_ex_mem.mem.mem_write}};

   data_memory #(
      .NB_DEPTH (NB_MEM_ADDR)
   ) u_dmem (
      .i_clk     (i_clk),
      .i_addr    (word_addr),
      .i_data    (st_lanes),
      .i_col_we  (col_we),
      .i_read_en (i_ex_mem.mem.mem_read),
      .o_data    (o_mem_data)
   );

   always_ff @(posedge i_clk) begin
      if (i_rst) begin
         o_mem_valid <= 1'b0;
      end else begin
         o_mem_valid <= i_ex_valid;
      end
   end

   // alu result keeps the low address bits for load lane select
   always_ff @(posedge i_clk) begin
      o_alu_data <= i_ex_mem.alu_res;
      o_wb_ctl   <= i_ex_mem.wb;
   end

endmodule

// ==== src/data_memory.sv ====
`timescale 1ns/100ps

module data_memory import mips_pkg::*; #(
   parameter int NB_DEPTH = NB_MEM_ADDR
) (
   input  logic               i_clk,
   input  logic [NB_DEPTH-1:0] i_addr,
   input  logic [NB_DATA-1:0] i_data,
   input  logic [NB_COL-1:0]  i_col_we,
   input  logic               i_read_en,
   output logic [NB_DATA-1:0] o_data
);

   logic [NB_DATA-1:0] mem [2**NB_DEPTH];

   // one write enable per byte column
   always_ff @(posedge i_clk) begin
      for (int c = 0; c < NB_COL; c++) begin
         if (i_col_we[c]) begin
            mem[i_addr][c*NB_BYTE +: NB_BYTE] <= i_data[c*NB_BYTE +: NB_BYTE];
         end
      end
   end

   // registered read, old data on a same-address write
   always_ff @(posedge i_clk) begin
      if (i_read_en) begin
         o_data <= mem[i_addr];
      end
   end

endmodule

// ==== src/alu_execute.sv ====
`timescale 1ns/100ps

module alu_execute import mips_pkg::*; (
   input  logic    i_clk,
   input  logic    i_rst,
   input  id_ex_t  i_id_ex,
   input  logic    i_id_valid,
   output ex_mem_t o_ex_mem,
   output logic    o_ex_valid
);

   logic [NB_DATA-1:0] op_a;
   logic [NB_DATA-1:0] op_b;
   logic [NB_DATA-1:0] alu_res;
   ex_mem_t            ex_next;

   assign op_a = i_id_ex.rs_data;

   always_comb begin
      if (!i_id_ex.ex.use_imm) begin
         op_b = i_id_ex.rt_data;
      end else if (i_id_ex.ex.imm_zero_ext) begin
         op_b = zero_ext16(i_id_ex.imm[15:0]);   // andi, ori
      end else begin
         op_b = i_id_ex.imm;
      end
   end

   always_comb begin
      case (i_id_ex.ex.alu_op)
         ALU_ADD: alu_res = op_a + op_b;          // also load/store address
         ALU_SUB: alu_res = op_a - op_b;
         ALU_AND: alu_res = op_a & op_b;
         ALU_OR:  alu_res = op_a | op_b;
         ALU_XOR: alu_res = op_a ^ op_b;
         ALU_SLT: alu_res = {{(NB_DATA-1){1'b0}}, $signed(op_a) < $signed(op_b)};
         ALU_LUI: alu_res = {op_b[15:0], 16'h0000};
         default: alu_res = '0;
      endcase
   end

   // side effects only when the slot is valid
   always_comb begin
      ex_next               = '{mem: i_id_ex.mem, wb: i_id_ex.wb,
                                alu_res: alu_res, st_data: i_id_ex.rt_data};
      ex_next.mem.mem_read  = i_id_ex.mem.mem_read && i_id_valid;
      ex_next.mem.mem_write = i_id_ex.mem.mem_write && i_id_valid;
      ex_next.wb.reg_write  = i_id_ex.wb.reg_write && i_id_valid;
   end

   always_ff @(posedge i_clk) begin
      if (i_rst) begin
         o_ex_valid <= 1'b0;
      end else begin
         o_ex_valid <= i_id_valid;
      end
   end

   always_ff @(posedge i_clk) begin
      o_ex_mem <= ex_next;
   end

endmodule

// ==== src/instr_decode.sv ====
`timescale 1ns/100ps

module instr_decode import mips_pkg::*; (
   input  logic               i_clk,
   input  logic               i_rst,
   input  logic               i_wb_cyc,
   input  logic               i_wb_stb,
   input  logic               i_wb_we,
   input  logic [NB_DATA-1:0] i_wb_dat,
   output logic [NB_DATA-1:0] o_wb_dat,
   output logic               o_wb_ack,
   output logic [NB_REG-1:0]  o_rs_idx,
   output logic [NB_REG-1:0]  o_rt_idx,
   input  logic [NB_DATA-1:0] i_rs_data,
   input  logic [NB_DATA-1:0] i_rt_data,
   input  ctrl_wb_t           i_ex_wb,    // instruction sitting in execute
   input  ctrl_wb_t           i_mem_wb,   // instruction sitting in memory
   output id_ex_t             o_id_ex,
   output logic               o_id_valid
);

   logic [5:0]        opcode;
   logic [5:0]        funct;
   logic [NB_REG-1:0] rd;
   logic [15:0]       imm;
   ctrl_ex_t          ctl_ex;
   ctrl_mem_t         ctl_mem;
   ctrl_wb_t          ctl_wb;
   logic              supported;
   logic              use_rs;
   logic              use_rt;
   logic              hit_ex;
   logic              hit_mem;
   logic              capture;

   assign opcode   = i_wb_dat[31:26];
   assign o_rs_idx = i_wb_dat[25:21];
   assign o_rt_idx = i_wb_dat[20:16];
   assign rd       = i_wb_dat[15:11];
   assign imm      = i_wb_dat[15:0];
   assign funct    = i_wb_dat[5:0];

   assign o_wb_dat = '0;   // reads return zero

   always_comb begin
      ctl_ex    = '{alu_op: ALU_ADD, use_imm: 1'b0, imm_zero_ext: 1'b0};
      ctl_mem   = '{mem_read: 1'b0, mem_write: 1'b0, mem_size: MEM_WORD};
      ctl_wb    = '{reg_write: 1'b0, mem_to_reg: 1'b0, load_unsigned: 1'b0,
                    mem_size: MEM_WORD, dst: o_rt_idx};
      supported = 1'b1;
      use_rs    = 1'b1;
      use_rt    = 1'b0;
      case (opcode_e'(opcode))
         OP_RTYPE: begin
            use_rt           = 1'b1;
            ctl_wb.reg_write = 1'b1;
            ctl_wb.dst       = rd;
            case (funct_e'(funct))
               F_ADDU:  ctl_ex.alu_op = ALU_ADD;
               F_SUBU:  ctl_ex.alu_op = ALU_SUB;
               F_AND:   ctl_ex.alu_op = ALU_AND;
               F_OR:    ctl_ex.alu_op = ALU_OR;
               F_XOR:   ctl_ex.alu_op = ALU_XOR;
               F_SLT:   ctl_ex.alu_op = ALU_SLT;
               default: supported = 1'b0;
            endcase
         end
         OP_ADDIU, OP_ANDI, OP_ORI, OP_LUI: begin
            ctl_ex.use_imm   = 1'b1;
            ctl_wb.reg_write = 1'b1;
            if (opcode_e'(opcode) == OP_ANDI) ctl_ex.alu_op = ALU_AND;
            if (opcode_e'(opcode) == OP_ORI) ctl_ex.alu_op = ALU_OR;
            ctl_ex.imm_zero_ext = (opcode_e'(opcode) == OP_ANDI) ||
                                  (opcode_e'(opcode) == OP_ORI);
            if (opcode_e'(opcode) == OP_LUI) begin
               ctl_ex.alu_op = ALU_LUI;
               use_rs        = 1'b0;   // lui has no register source
            end
         end
         OP_LB, OP_LBU, OP_LH, OP_LHU, OP_LW: begin
            ctl_ex.use_imm       = 1'b1;
            ctl_mem.mem_read     = 1'b1;
            ctl_wb.reg_write     = 1'b1;
            ctl_wb.mem_to_reg    = 1'b1;
            ctl_wb.load_unsigned = (opcode_e'(opcode) == OP_LBU) ||
                                   (opcode_e'(opcode) == OP_LHU);
            if (opcode[1:0] == 2'b00) ctl_mem.mem_size = MEM_BYTE;   // lb, lbu
            if (opcode[1:0] == 2'b01) ctl_mem.mem_size = MEM_HALF;   // lh, lhu
         end
         OP_SB, OP_SH, OP_SW: begin
            use_rt            = 1'b1;   // store data
            ctl_ex.use_imm    = 1'b1;
            ctl_mem.mem_write = 1'b1;
            if (opcode[1:0] == 2'b00) ctl_mem.mem_size = MEM_BYTE;
            if (opcode[1:0] == 2'b01) ctl_mem.mem_size = MEM_HALF;
         end
         default: supported = 1'b0;
      endcase
      if (!supported) begin
         use_rs = 1'b0;   // bubble, never stalls
         use_rt = 1'b0;
      end
      ctl_wb.mem_size = ctl_mem.mem_size;
   end

   // scoreboard against the two stages ahead, writeback goes through the rf bypass
   assign hit_ex = o_id_valid && i_ex_wb.reg_write && (i_ex_wb.dst != '0) &&
                   ((use_rs && i_ex_wb.dst == o_rs_idx) ||
                    (use_rt && i_ex_wb.dst == o_rt_idx));
   assign hit_mem = i_mem_wb.reg_write && (i_mem_wb.dst != '0) &&
                    ((use_rs && i_mem_wb.dst == o_rs_idx) ||
                     (use_rt && i_mem_wb.dst == o_rt_idx));

   assign o_wb_ack = i_wb_cyc && i_wb_stb && !(i_wb_we && (hit_ex || hit_mem));
   assign capture  = o_wb_ack && i_wb_we && supported;

   always_ff @(posedge i_clk) begin
      if (i_rst) begin
         o_id_valid <= 1'b0;
      end else begin
         o_id_valid <= capture;
      end
   end

   always_ff @(posedge i_clk) begin
      if (capture) begin
         o_id_ex.ex      <= ctl_ex;
         o_id_ex.mem     <= ctl_mem;
         o_id_ex.wb      <= ctl_wb;
         o_id_ex.rs_data <= i_rs_data;
         o_id_ex.rt_data <= i_rt_data;
         o_id_ex.imm     <= sign_ext16(imm);
      end
   end

endmodule

// ==== src/reg_file.sv ====
`timescale 1ns/100ps

module reg_file import mips_pkg::*; (
   input  logic               i_clk,
   input  logic               i_rst,
   input  logic [NB_REG-1:0]  i_rs_idx,
   input  logic [NB_REG-1:0]  i_rt_idx,
   output logic [NB_DATA-1:0] o_rs_data,
   output logic [NB_DATA-1:0] o_rt_data,
   input  logic               i_we,
   input  logic [NB_REG-1:0]  i_wr_idx,
   input  logic [NB_DATA-1:0] i_wr_data
);

   logic [NB_DATA-1:0] regs [2**NB_REG];

   always_ff @(posedge i_clk) begin
      if (i_rst) begin
         for (int i = 0; i < 2**NB_REG; i++) begin
            regs[i] <= '0;
         end
      end else if (i_we && i_wr_idx != '0) begin
         regs[i_wr_idx] <= i_wr_data;
      end
   end

   // r0 reads zero, a write in flight is bypassed to the reader
   always_comb begin
      if (i_rs_idx == '0) o_rs_data = '0;
      else if (i_we && i_wr_idx == i_rs_idx) o_rs_data = i_wr_data;
      else o_rs_data = regs[i_rs_idx];

      if (i_rt_idx == '0) o_rt_data = '0;
      else if (i_we && i_wr_idx == i_rt_idx) o_rt_data = i_wr_data;
      else o_rt_data = regs[i_rt_idx];
   end

endmodule

// ==== src/mips_pkg.sv ====
package mips_pkg;

   localparam int NB_DATA     = 32;
   localparam int NB_REG      = 5;
   localparam int NB_MEM_ADDR = 8;                  // word address bits of data memory
   localparam int NB_COL      = 4;
   localparam int NB_BYTE     = NB_DATA / NB_COL;   // width of one memory column

   // primary opcodes of the supported subset
   typedef enum logic [5:0] {
      OP_RTYPE = 6'h00,
      OP_ADDIU = 6'h09,
      OP_ANDI  = 6'h0c,
      OP_ORI   = 6'h0d,
      OP_LUI   = 6'h0f,
      OP_LB    = 6'h20,
      OP_LH    = 6'h21,
      OP_LW    = 6'h23,
      OP_LBU   = 6'h24,
      OP_LHU   = 6'h25,
      OP_SB    = 6'h28,
      OP_SH    = 6'h29,
      OP_SW    = 6'h2b
   } opcode_e;

   // function field of r-type
   typedef enum logic [5:0] {
      F_ADDU = 6'h21,
      F_SUBU = 6'h23,
      F_AND  = 6'h24,
      F_OR   = 6'h25,
      F_XOR  = 6'h26,
      F_SLT  = 6'h2a
   } funct_e;

   typedef enum logic [2:0] {
      ALU_ADD,
      ALU_SUB,
      ALU_AND,
      ALU_OR,
      ALU_XOR,
      ALU_SLT,
      ALU_LUI
   } alu_op_e;

   typedef enum logic [1:0] {
      MEM_BYTE,
      MEM_HALF,
      MEM_WORD
   } mem_size_e;

   typedef struct packed {
      alu_op_e alu_op;
      logic    use_imm;
      logic    imm_zero_ext;
   } ctrl_ex_t;

   typedef struct packed {
      logic      mem_read;
      logic      mem_write;
      mem_size_e mem_size;
   } ctrl_mem_t;

   typedef struct packed {
      logic              reg_write;
      logic              mem_to_reg;
      logic              load_unsigned;
      mem_size_e         mem_size;
      logic [NB_REG-1:0] dst;
   } ctrl_wb_t;

   typedef struct packed {
      ctrl_ex_t           ex;
      ctrl_mem_t          mem;
      ctrl_wb_t           wb;
      logic [NB_DATA-1:0] rs_data;
      logic [NB_DATA-1:0] rt_data;
      logic [NB_DATA-1:0] imm;        // already sign extended
   } id_ex_t;

   typedef struct packed {
      ctrl_mem_t          mem;
      ctrl_wb_t           wb;
      logic [NB_DATA-1:0] alu_res;    // doubles as load/store address
      logic [NB_DATA-1:0] st_data;
   } ex_mem_t;

   typedef struct packed {
      logic [NB_REG-1:0]  idx;
      logic [NB_DATA-1:0] data;
   } wb_result_t;

   function automatic logic [NB_DATA-1:0] sign_ext16(input logic [15:0] v);
      return {{(NB_DATA-16){v[15]}}, v};
   endfunction

   function automatic logic [NB_DATA-1:0] zero_ext16(input logic [15:0] v);
      return {{(NB_DATA-16){1'b0}}, v};
   endfunction

   function automatic logic [NB_DATA-1:0] ext_byte(input logic [NB_BYTE-1:0] b,
                                                   input logic is_unsigned);
      return {{(NB_DATA-NB_BYTE){b[NB_BYTE-1] & ~is_unsigned}}, b};
   endfunction

   function automatic logic [NB_DATA-1:0] ext_half(input logic [15:0] h,
                                                   input logic is_unsigned);
      return {{(NB_DATA-16){h[15] & ~is_unsigned}}, h};
   endfunction

endpackage
